// File: logic/video_defs.svh
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// line geometry, in clocks
`define H_DISPLAY 256
`define H_FRONT 7
`define H_SYNC 23
`define H_BACK 23
`define H_TOTAL 309

// frame geometry, in lines
`define V_DISPLAY 240
`define V_BOTTOM 14
`define V_SYNC 3
`define V_TOP 5
`define V_TOTAL 262

// slip counter constants
// a timer runs from its stop value up through 511 and wraps to 0
`define BALL_H_STOP 204
`define BALL_V_STOP 251
`define BALL_RESET_OFFSET 128
// stripe is drawn for the last four counts before the wrap
`define BALL_GFX_START 508
`define BALL_STEP 2

// edge collision rows and columns
`define COLLIDE_V_ROW 240
`define COLLIDE_H_COL 256
`define COLLIDE_H_ROW 255

`endif

// File: logic/video_timing_pkg.sv
package video_timing_pkg;

  // wide enough for both H_TOTAL and V_TOTAL
  localparam int POS_W = 9;

  // pixel column or line number
  typedef logic [POS_W-1:0] raster_pos_t;

  // phase within one line or one frame
  // the same sequence serves both axes
  typedef enum logic [1:0]
  {
    active,
    front_porch,
    sync_pulse,
    back_porch
  } line_phase_t;

endpackage

// File: logic/ball_pkg.sv
package ball_pkg;

  // slip counter width, wraps at 512
  localparam int TIMER_W = 9;

  typedef logic [TIMER_W-1:0] ball_timer_t;

  // sign of the move step added to a stop value
  typedef enum logic
  {
    dir_neg,
    dir_pos
  } move_dir_t;

  // colour bits, blue on top and red at the bottom
  typedef struct packed
  {
    logic blue;
    logic green;
    logic red;
  } rgb_t;

endpackage

// File: logic/raster_sync.sv
`timescale 1ns/10ps
`include "video_defs.svh"

module raster_sync
(
  input  logic                        ball_horiz_collide,
  input  logic                        reset,
  output video_timing_pkg::raster_pos_t hpos,
  output video_timing_pkg::raster_pos_t vpos,
  output logic                        display_on,
  output logic                        hsync_raw,
  output logic                        vsync_raw,
  output logic                        line_start,
  output logic                        frame_start
);

  import video_timing_pkg::*;

  // last position of each phase
  localparam raster_pos_t H_ACT_END  = raster_pos_t'(`H_DISPLAY - 1);
  localparam raster_pos_t H_FP_END   = raster_pos_t'(`H_DISPLAY + `H_FRONT - 1);
  localparam raster_pos_t H_SYNC_END = raster_pos_t'(`H_DISPLAY + `H_FRONT + `H_SYNC - 1);
  localparam raster_pos_t H_LAST     = raster_pos_t'(`H_TOTAL - 1);

  localparam raster_pos_t V_ACT_END  = raster_pos_t'(`V_DISPLAY - 1);
  localparam raster_pos_t V_FP_END   = raster_pos_t'(`V_DISPLAY + `V_BOTTOM - 1);
  localparam raster_pos_t V_SYNC_END = raster_pos_t'(`V_DISPLAY + `V_BOTTOM + `V_SYNC - 1);
  localparam raster_pos_t V_LAST     = raster_pos_t'(`V_TOTAL - 1);

  line_phase_t h_phase;
  line_phase_t h_phase_next;
  line_phase_t v_phase;
  line_phase_t v_phase_next;
  logic        h_last;

  assign h_last = (hpos == H_LAST);

  // phase steps on the last count of the current phase
  always_comb
  begin
    h_phase_next = h_phase;
    case (h_phase)
      active:      if (hpos == H_ACT_END)  h_phase_next = front_porch;
      front_porch: if (hpos == H_FP_END)   h_phase_next = sync_pulse;
      sync_pulse:  if (hpos == H_SYNC_END) h_phase_next = back_porch;
      back_porch:  if (h_last)             h_phase_next = active;
      default:     h_phase_next = active;
    endcase
  end

  always_comb
  begin
    v_phase_next = v_phase;
    case (v_phase)
      active:      if (vpos == V_ACT_END)  v_phase_next = front_porch;
      front_porch: if (vpos == V_FP_END)   v_phase_next = sync_pulse;
      sync_pulse:  if (vpos == V_SYNC_END) v_phase_next = back_porch;
      back_porch:  if (vpos == V_LAST)     v_phase_next = active;
      default:     v_phase_next = active;
    endcase
  end

  always_ff @(posedge ball_horiz_collide or posedge reset)
  begin
    if (reset)
    begin
      hpos    <= '0;
      vpos    <= '0;
      h_phase <= active;
      v_phase <= active;
    end
    else
    begin
      h_phase <= h_phase_next;
      if (h_last)
      begin
        hpos    <= '0;
        // vertical side only moves at the end of a line
        v_phase <= v_phase_next;
        if (vpos == V_LAST)
          vpos <= '0;
        else
          vpos <= vpos + 1'b1;
      end
      else
        hpos <= hpos + 1'b1;
    end
  end

  // syncs are active low
  assign hsync_raw   = (h_phase != sync_pulse);
  assign vsync_raw   = (v_phase != sync_pulse);
  assign display_on  = (h_phase == active) && (v_phase == active);
  assign line_start  = (hpos == '0);
  assign frame_start = line_start && (vpos == '0);

endmodule

// File: logic/ball_slip_timer.sv
`timescale 1ns/10ps
`include "video_defs.svh"

module ball_slip_timer
(
  input  logic                          ball_horiz_collide,
  input  logic                          reset,
  input  logic                          line_start,
  input  ball_pkg::move_dir_t           horiz_dir,
  input  ball_pkg::move_dir_t           vert_dir,
  input  video_timing_pkg::raster_pos_t hpos_in,
  input  video_timing_pkg::raster_pos_t vpos_in,
  input  logic                          display_in,
  input  logic                          hsync_in,
  input  logic                          vsync_in,
  output video_timing_pkg::raster_pos_t hpos,
  output video_timing_pkg::raster_pos_t vpos,
  output logic                          display_on,
  output logic                          hsync_raw,
  output logic                          vsync_raw,
  output logic                          ball_hgfx,
  output logic                          ball_vgfx
);

  import ball_pkg::*;

  localparam ball_timer_t H_STOP     = ball_timer_t'(`BALL_H_STOP);
  localparam ball_timer_t H_STOP_NEG = ball_timer_t'(`BALL_H_STOP - `BALL_STEP);
  localparam ball_timer_t H_STOP_POS = ball_timer_t'(`BALL_H_STOP + `BALL_STEP);
  localparam ball_timer_t V_STOP_NEG = ball_timer_t'(`BALL_V_STOP - `BALL_STEP);
  localparam ball_timer_t V_STOP_POS = ball_timer_t'(`BALL_V_STOP + `BALL_STEP);
  localparam ball_timer_t H_RESET    = ball_timer_t'(`BALL_H_STOP - `BALL_RESET_OFFSET);
  localparam ball_timer_t V_RESET    = ball_timer_t'(`BALL_V_STOP - `BALL_RESET_OFFSET);
  localparam ball_timer_t GFX_START  = ball_timer_t'(`BALL_GFX_START);

  ball_timer_t htimer;
  ball_timer_t vtimer;
  ball_timer_t h_reload;
  ball_timer_t v_reload;

  // the step only slips the horizontal timer on the line where vtimer sits at zero,
  // so the ball moves once per frame
  always_comb
  begin
    if (vtimer == '0)
      h_reload = (horiz_dir == dir_neg) ? H_STOP_NEG : H_STOP_POS;
    else
      h_reload = H_STOP;
    v_reload = (vert_dir == dir_neg) ? V_STOP_NEG : V_STOP_POS;
  end

  always_ff @(posedge ball_horiz_collide or posedge reset)
  begin
    if (reset)
    begin
      htimer <= H_RESET;
      vtimer <= V_RESET;
    end
    else
    begin
      if (htimer == '0)
        htimer <= h_reload;
      else
        htimer <= htimer + 1'b1;

      // one vertical count per line
      if (line_start)
      begin
        if (vtimer == '0)
          vtimer <= v_reload;
        else
          vtimer <= vtimer + 1'b1;
      end
    end
  end

  // stage 2 register, stripes stay lined up with the raster
  always_ff @(posedge ball_horiz_collide or posedge reset)
  begin
    if (reset)
    begin
      hpos       <= '0;
      vpos       <= '0;
      display_on <= 1'b0;
      hsync_raw  <= 1'b1;
      vsync_raw  <= 1'b1;
      ball_hgfx  <= 1'b0;
      ball_vgfx  <= 1'b0;
    end
    else
    begin
      hpos       <= hpos_in;
      vpos       <= vpos_in;
      display_on <= display_in;
      hsync_raw  <= hsync_in;
      vsync_raw  <= vsync_in;
      ball_hgfx  <= (htimer >= GFX_START);
      ball_vgfx  <= (vtimer >= GFX_START);
    end
  end

endmodule

// File: logic/bounce_control.sv
`timescale 1ns/10ps
`include "video_defs.svh"

module bounce_control
(
  input  logic                          ball_horiz_collide,
  input  logic                          reset,
  input  video_timing_pkg::raster_pos_t hpos,
  input  video_timing_pkg::raster_pos_t vpos,
  input  logic                          ball_hgfx,
  input  logic                          ball_vgfx,
  output ball_pkg::move_dir_t           horiz_dir,
  output ball_pkg::move_dir_t           vert_dir
);

  import ball_pkg::*;

  logic vert_hit;
  logic horiz_hit;
  logic vert_hit_q;
  logic horiz_hit_q;

  // vertical stripe reaching the bottom rows
  assign vert_hit = ball_vgfx && (vpos >= `COLLIDE_V_ROW);

  // horizontal stripe past the right edge, sampled on a single row
  assign horiz_hit = ball_hgfx && (hpos >= `COLLIDE_H_COL) && (vpos == `COLLIDE_H_ROW);

  always_ff @(posedge ball_horiz_collide or posedge reset)
  begin
    if (reset)
    begin
      vert_hit_q  <= 1'b0;
      horiz_hit_q <= 1'b0;
      horiz_dir   <= dir_neg;
      vert_dir    <= dir_pos;
    end
    else
    begin
      vert_hit_q  <= vert_hit;
      horiz_hit_q <= horiz_hit;

      // reverse once per rising edge of a hit
      if (vert_hit && !vert_hit_q)
        vert_dir <= (vert_dir == dir_neg) ? dir_pos : dir_neg;
      if (horiz_hit && !horiz_hit_q)
        horiz_dir <= (horiz_dir == dir_neg) ? dir_pos : dir_neg;
    end
  end

endmodule

// File: logic/pixel_mixer.sv
`timescale 1ns/10ps

module pixel_mixer
(
  input  logic                          ball_horiz_collide,
  input  logic                          reset,
  input  video_timing_pkg::raster_pos_t hpos,
  input  video_timing_pkg::raster_pos_t vpos,
  input  logic                          display_on,
  input  logic                          hsync_raw,
  input  logic                          vsync_raw,
  input  logic                          ball_hgfx,
  input  logic                          ball_vgfx,
  output logic                          hsync,
  output logic                          vsync,
  output ball_pkg::rgb_t                rgb
);

  import ball_pkg::*;

  logic grid_gfx;
  logic ball_gfx;
  rgb_t rgb_next;

  // dot every 8 pixels on every 8th line
  assign grid_gfx = (hpos[2:0] == 3'd0) && (vpos[2:0] == 3'd0);

  // the ball is where both stripes cross, drawn white
  assign ball_gfx = ball_hgfx && ball_vgfx;

  assign rgb_next.red   = display_on && ball_hgfx;
  assign rgb_next.green = display_on && (grid_gfx || ball_gfx);
  assign rgb_next.blue  = display_on && ball_vgfx;

  // stage 3 output register
  always_ff @(posedge ball_horiz_collide or posedge reset)
  begin
    if (reset)
    begin
      hsync <= 1'b1;
      vsync <= 1'b1;
      rgb   <= '0;
    end
    else
    begin
      hsync <= hsync_raw;
      vsync <= vsync_raw;
      rgb   <= rgb_next;
    end
  end

endmodule

// File: logic/ball_video_top.sv
`timescale 1ns/10ps

module ball_video_top
(
  input  logic           ball_horiz_collide,
  input  logic           reset,
  output logic           hsync,
  output logic           vsync,
  output ball_pkg::rgb_t rgb
);

  import video_timing_pkg::*;
  import ball_pkg::*;

  // stage 1 raster
  raster_pos_t s1_hpos;
  raster_pos_t s1_vpos;
  logic        s1_display_on;
  logic        s1_hsync_raw;
  logic        s1_vsync_raw;
  logic        line_start;
  // frame marker, watched by the bound checks
  logic        frame_start;

  // stage 2, one clock later
  raster_pos_t s2_hpos;
  raster_pos_t s2_vpos;
  logic        s2_display_on;
  logic        s2_hsync_raw;
  logic        s2_vsync_raw;
  logic        ball_hgfx;
  logic        ball_vgfx;

  move_dir_t   horiz_dir;
  move_dir_t   vert_dir;

  raster_sync i_raster_sync
  (
    .ball_horiz_collide (ball_horiz_collide),
    .reset              (reset),
    .hpos               (s1_hpos),
    .vpos               (s1_vpos),
    .display_on         (s1_display_on),
    .hsync_raw          (s1_hsync_raw),
    .vsync_raw          (s1_vsync_raw),
    .line_start         (line_start),
    .frame_start        (frame_start)
  );

  ball_slip_timer i_ball_slip_timer
  (
    .ball_horiz_collide (ball_horiz_collide),
    .reset              (reset),
    .line_start         (line_start),
    .horiz_dir          (horiz_dir),
    .vert_dir           (vert_dir),
    .hpos_in            (s1_hpos),
    .vpos_in            (s1_vpos),
    .display_in         (s1_display_on),
    .hsync_in           (s1_hsync_raw),
    .vsync_in           (s1_vsync_raw),
    .hpos               (s2_hpos),
    .vpos               (s2_vpos),
    .display_on         (s2_display_on),
    .hsync_raw          (s2_hsync_raw),
    .vsync_raw          (s2_vsync_raw),
    .ball_hgfx          (ball_hgfx),
    .ball_vgfx          (ball_vgfx)
  );

  bounce_control i_bounce_control
  (
    .ball_horiz_collide (ball_horiz_collide),
    .reset              (reset),
    .hpos               (s2_hpos),
    .vpos               (s2_vpos),
    .ball_hgfx          (ball_hgfx),
    .ball_vgfx          (ball_vgfx),
    .horiz_dir          (horiz_dir),
    .vert_dir           (vert_dir)
  );

  pixel_mixer i_pixel_mixer
  (
    .ball_horiz_collide (ball_horiz_collide),
    .reset              (reset),
    .hpos               (s2_hpos),
    .vpos               (s2_vpos),
    .display_on         (s2_display_on),
    .hsync_raw          (s2_hsync_raw),
    .vsync_raw          (s2_vsync_raw),
    .ball_hgfx          (ball_hgfx),
    .ball_vgfx          (ball_vgfx),
    .hsync              (hsync),
    .vsync              (vsync),
    .rgb                (rgb)
  );

endmodule

// File: test/ball_video_props.sv
`timescale 1ns/10ps
`include "video_defs.svh"

module ball_video_props
(
  input logic                          ball_horiz_collide,
  input logic                          reset,
  input logic                          hsync,
  input ball_pkg::rgb_t                rgb,
  input video_timing_pkg::raster_pos_t hpos,
  input video_timing_pkg::raster_pos_t vpos,
  input logic                          frame_start,
  input ball_pkg::move_dir_t           horiz_dir,
  input ball_pkg::move_dir_t           vert_dir
);

  import ball_pkg::*;

  int        low_len;
  move_dir_t horiz_dir_q;
  move_dir_t vert_dir_q;
  logic      horiz_flipped;
  logic      vert_flipped;

  // length of the current hsync pulse and flips seen in this frame
  always_ff @(posedge ball_horiz_collide or posedge reset)
  begin
    if (reset)
    begin
      low_len       <= 0;
      horiz_dir_q   <= dir_neg;
      vert_dir_q    <= dir_pos;
      horiz_flipped <= 1'b0;
      vert_flipped  <= 1'b0;
    end
    else
    begin
      low_len     <= hsync ? 0 : low_len + 1;
      horiz_dir_q <= horiz_dir;
      vert_dir_q  <= vert_dir;
      if (frame_start)
        horiz_flipped <= 1'b0;
      else if (horiz_dir != horiz_dir_q)
        horiz_flipped <= 1'b1;
      if (frame_start)
        vert_flipped <= 1'b0;
      else if (vert_dir != vert_dir_q)
        vert_flipped <= 1'b1;
    end
  end

  hsync_pulse_len: assert property (@(posedge ball_horiz_collide) disable iff (reset)
    $rose(hsync) |-> (low_len == `H_SYNC))
  else
    $error("hsync low pulse lasted %0d clocks", low_len);

  // stage 2 position, rgb follows one clock later
  blank_is_black: assert property (@(posedge ball_horiz_collide) disable iff (reset)
    !((hpos < `H_DISPLAY) && (vpos < `V_DISPLAY)) |=> (rgb == '0))
  else
    $error("rgb is not black outside the display area");

  horiz_flip_once: assert property (@(posedge ball_horiz_collide) disable iff (reset)
    (horiz_dir != horiz_dir_q) |-> !horiz_flipped)
  else
    $error("horizontal direction changed twice in one frame");

  vert_flip_once: assert property (@(posedge ball_horiz_collide) disable iff (reset)
    (vert_dir != vert_dir_q) |-> !vert_flipped)
  else
    $error("vertical direction changed twice in one frame");

endmodule

// File: test/ball_video_tb.sv
`timescale 1ns/10ps
`include "video_defs.svh"

module ball_video_tb;

  import video_timing_pkg::*;
  import ball_pkg::*;

  localparam int NUM_FRAMES  = 6;
  localparam int NUM_PROBES  = 20;
  localparam int CYCLE_LIMIT = 7 * `H_TOTAL * `V_TOTAL;

  localparam raster_pos_t H_SYNC_FIRST = raster_pos_t'(`H_DISPLAY + `H_FRONT);
  localparam raster_pos_t H_SYNC_AFTER = raster_pos_t'(`H_DISPLAY + `H_FRONT + `H_SYNC);
  localparam raster_pos_t V_SYNC_FIRST = raster_pos_t'(`V_DISPLAY + `V_BOTTOM);
  localparam raster_pos_t V_SYNC_AFTER = raster_pos_t'(`V_DISPLAY + `V_BOTTOM + `V_SYNC);
  localparam raster_pos_t H_LAST       = raster_pos_t'(`H_TOTAL - 1);
  localparam raster_pos_t V_LAST       = raster_pos_t'(`V_TOTAL - 1);
  localparam ball_timer_t GFX_START    = ball_timer_t'(`BALL_GFX_START);

  typedef enum logic [1:0]
  {
    k_blank,
    k_grid,
    k_background,
    k_ball
  } probe_kind_t;

  typedef struct packed
  {
    logic [3:0]  frame;
    raster_pos_t h;
    raster_pos_t v;
    probe_kind_t kind;
  } probe_t;

  // one pixel on its way through the model pipeline
  typedef struct packed
  {
    logic        valid;
    logic [3:0]  frame;
    raster_pos_t h;
    raster_pos_t v;
    logic        hgfx;
    logic        vgfx;
  } pixel_t;

  logic   ball_horiz_collide;
  logic   reset;
  logic   hsync;
  logic   vsync;
  rgb_t   rgb;
  probe_t probes [NUM_PROBES];
  int     cycles = 0;

  // reference model state
  raster_pos_t m_h;
  raster_pos_t m_v;
  logic [3:0]  m_frame;
  ball_timer_t m_htimer;
  ball_timer_t m_vtimer;
  move_dir_t   m_hdir;
  move_dir_t   m_vdir;
  logic        m_hhit_q;
  logic        m_vhit_q;
  pixel_t      m_s2;
  pixel_t      m_out;

  ball_video_top i_ball_video_top
  (
    .ball_horiz_collide (ball_horiz_collide),
    .reset              (reset),
    .hsync              (hsync),
    .vsync              (vsync),
    .rgb                (rgb)
  );

  bind ball_video_top ball_video_props i_ball_video_props
  (
    .ball_horiz_collide (ball_horiz_collide),
    .reset              (reset),
    .hsync              (hsync),
    .rgb                (rgb),
    .hpos               (s2_hpos),
    .vpos               (s2_vpos),
    .frame_start        (frame_start),
    .horiz_dir          (horiz_dir),
    .vert_dir           (vert_dir)
  );

  initial
  begin
    ball_horiz_collide = 1'b0;
    forever
      #10 ball_horiz_collide = ~ball_horiz_collide;
  end

  task automatic end_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_rgb(input rgb_t expected, input rgb_t actual);
    if (actual !== expected)
    begin
      $display("error at %0t ns: rgb expected %b, got %b", $time, expected, actual);
      end_with_failure();
    end
  endtask

  task automatic check_sync(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
      end_with_failure();
    end
  endtask

  // rows in output order: frame, column, line, kind
  task automatic load_probes();
    probes[0]  = '{4'd0, 9'd0,   9'd0,   k_grid};
    probes[1]  = '{4'd0, 9'd300, 9'd0,   k_blank};
    probes[2]  = '{4'd0, 9'd17,  9'd33,  k_background};
    probes[3]  = '{4'd0, 9'd20,  9'd50,  k_background};
    probes[4]  = '{4'd0, 9'd40,  9'd245, k_blank};
    probes[5]  = '{4'd1, 9'd8,   9'd40,  k_grid};
    probes[6]  = '{4'd1, 9'd123, 9'd122, k_ball};
    probes[7]  = '{4'd1, 9'd124, 9'd123, k_ball};
    probes[8]  = '{4'd1, 9'd270, 9'd123, k_blank};
    probes[9]  = '{4'd2, 9'd126, 9'd121, k_ball};
    probes[10] = '{4'd2, 9'd201, 9'd199, k_background};
    probes[11] = '{4'd2, 9'd200, 9'd200, k_grid};
    probes[12] = '{4'd3, 9'd128, 9'd119, k_ball};
    probes[13] = '{4'd3, 9'd248, 9'd232, k_grid};
    probes[14] = '{4'd3, 9'd10,  9'd255, k_blank};
    probes[15] = '{4'd4, 9'd48,  9'd8,   k_grid};
    probes[16] = '{4'd4, 9'd130, 9'd117, k_ball};
    probes[17] = '{4'd5, 9'd132, 9'd115, k_ball};
    probes[18] = '{4'd5, 9'd130, 9'd200, k_background};
    probes[19] = '{4'd5, 9'd255, 9'd239, k_background};
  endtask

  // red for the column stripe, blue for the line stripe, green for grid dots, white ball
  function automatic rgb_t expected_colour(input pixel_t p);
    rgb_t c;
    logic on;
    on      = p.valid && (p.h < `H_DISPLAY) && (p.v < `V_DISPLAY);
    c.red   = on && p.hgfx;
    c.blue  = on && p.vgfx;
    c.green = on && (((p.h[2:0] == 3'd0) && (p.v[2:0] == 3'd0)) || (p.hgfx && p.vgfx));
    return c;
  endfunction

  // ball probes sit where both stripes cross
  function automatic rgb_t probe_colour(input probe_kind_t kind);
    rgb_t c;
    c = '0;
    if (kind == k_grid)
      c.green = 1'b1;
    else if (kind == k_ball)
      c = '1;
    return c;
  endfunction

  function automatic logic expected_hsync(input pixel_t p);
    return !(p.valid && (p.h >= H_SYNC_FIRST) && (p.h < H_SYNC_AFTER));
  endfunction

  function automatic logic expected_vsync(input pixel_t p);
    return !(p.valid && (p.v >= V_SYNC_FIRST) && (p.v < V_SYNC_AFTER));
  endfunction

  function automatic ball_timer_t slipped_stop(input int stop, input move_dir_t dir);
    if (dir == dir_pos)
      return ball_timer_t'(stop + `BALL_STEP);
    else
      return ball_timer_t'(stop - `BALL_STEP);
  endfunction

  task automatic reset_model();
    m_h      = '0;
    m_v      = '0;
    m_frame  = '0;
    m_htimer = ball_timer_t'(`BALL_H_STOP - `BALL_RESET_OFFSET);
    m_vtimer = ball_timer_t'(`BALL_V_STOP - `BALL_RESET_OFFSET);
    m_hdir   = dir_neg;
    m_vdir   = dir_pos;
    m_hhit_q = 1'b0;
    m_vhit_q = 1'b0;
    m_s2     = '0;
    m_out    = '0;
  endtask

  // one clock of the model, two register stages from raster count to output
  task automatic step_model();
    logic      vhit;
    logic      hhit;
    move_dir_t hdir_next;
    move_dir_t vdir_next;
    m_out = m_s2;
    // hits are judged on the stage 2 pixel
    vhit = m_s2.vgfx && (m_s2.v >= `COLLIDE_V_ROW);
    hhit = m_s2.hgfx && (m_s2.h >= `COLLIDE_H_COL) && (m_s2.v == `COLLIDE_H_ROW);
    hdir_next = (hhit && !m_hhit_q) ? ((m_hdir == dir_neg) ? dir_pos : dir_neg) : m_hdir;
    vdir_next = (vhit && !m_vhit_q) ? ((m_vdir == dir_neg) ? dir_pos : dir_neg) : m_vdir;
    m_hhit_q = hhit;
    m_vhit_q = vhit;
    m_s2.valid = 1'b1;
    m_s2.frame = m_frame;
    m_s2.h     = m_h;
    m_s2.v     = m_v;
    m_s2.hgfx  = (m_htimer >= GFX_START);
    m_s2.vgfx  = (m_vtimer >= GFX_START);
    // horizontal stop slips only while the vertical timer sits at zero
    if (m_htimer != '0)
      m_htimer = m_htimer + 1'b1;
    else if (m_vtimer == '0)
      m_htimer = slipped_stop(`BALL_H_STOP, m_hdir);
    else
      m_htimer = ball_timer_t'(`BALL_H_STOP);
    if (m_h == '0)
      m_vtimer = (m_vtimer == '0) ? slipped_stop(`BALL_V_STOP, m_vdir) : m_vtimer + 1'b1;
    m_hdir = hdir_next;
    m_vdir = vdir_next;
    if (m_h == H_LAST)
    begin
      m_h = '0;
      if (m_v == V_LAST)
      begin
        m_v     = '0;
        m_frame = m_frame + 1'b1;
      end
      else
        m_v = m_v + 1'b1;
    end
    else
      m_h = m_h + 1'b1;
  endtask

  always @(posedge ball_horiz_collide)
  begin
    if (reset)
      reset_model();
    else
      step_model();
  end

  always @(posedge ball_horiz_collide)
  begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout: the run did not finish within %0d clocks", CYCLE_LIMIT);
      end_with_failure();
    end
  end

  initial
  begin
    int     idx;
    pixel_t p;
    idx   = 0;
    reset = 1'b1;
    load_probes();
    repeat (2) @(negedge ball_horiz_collide);
    reset = 1'b0;
    // output position follows the counted clocks, the sync checks tie it to the DUT
    while (!(m_out.valid && (m_out.frame == 4'(NUM_FRAMES))))
    begin
      @(negedge ball_horiz_collide);
      p = m_out;
      check_sync("hsync", expected_hsync(p), hsync);
      check_sync("vsync", expected_vsync(p), vsync);
      check_rgb(expected_colour(p), rgb);
      if ((idx < NUM_PROBES) && p.valid && (probes[idx].frame == p.frame) &&
          (probes[idx].h == p.h) && (probes[idx].v == p.v))
      begin
        check_rgb(probe_colour(probes[idx].kind), rgb);
        idx++;
      end
    end
    if (idx == NUM_PROBES)
    begin
      $display("*** TEST PASSED ***");
      $finish;
    end
    else
    begin
      $display("only %0d of %0d probe points were reached", idx, NUM_PROBES);
      end_with_failure();
    end
  end

endmodule

// File: project.f
+incdir+logic
logic/video_timing_pkg.sv
logic/ball_pkg.sv
logic/raster_sync.sv
logic/ball_slip_timer.sv
logic/bounce_control.sv
logic/pixel_mixer.sv
logic/ball_video_top.sv
test/ball_video_props.sv
test/ball_video_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f project.f --top-module ball_video_tb -o ball_video_sim \
  && ./obj_dir/ball_video_sim > sim.log 2>&1 \
  || echo "build or simulation returned an error"

cat sim.log 2>/dev/null

grep -qF "*** TEST PASSED ***" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
